/* synth_config.svh */
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

// System clock rate in Hz
`define SYNTH_CLK_HZ      50_000_000

// Key code width, also the LED width
`define SYNTH_KEY_W       4

// Signed audio sample
`define SYNTH_SAMPLE_W    16
`define SYNTH_AMPLITUDE   8192   // Square wave magnitude

// Clock cycles between sample opportunities
`define SYNTH_SAMPLE_DIV  16

`endif

/* synth_pkg.sv */
package synth_pkg;

    // Chromatic note names, encoded as the key code
    typedef enum logic [3:0] {
        NOTE_C  = 4'd0,
        NOTE_CS = 4'd1,
        NOTE_D  = 4'd2,
        NOTE_DS = 4'd3,
        NOTE_E  = 4'd4,
        NOTE_F  = 4'd5,
        NOTE_FS = 4'd6,
        NOTE_G  = 4'd7,
        NOTE_GS = 4'd8,
        NOTE_A  = 4'd9,
        NOTE_AS = 4'd10,
        NOTE_B  = 4'd11
    } note_t;

    parameter int NOTE_COUNT = 12;

    // Octave-zero frequencies in millihertz
    parameter logic [31:0] note_freq_mhz [NOTE_COUNT] = '{
        32'd16352, 32'd17324, 32'd18354, 32'd19445,   // C  C# D  D#
        32'd20602, 32'd21827, 32'd23125, 32'd24500,   // E  F  F# G
        32'd25957, 32'd27500, 32'd29135, 32'd30868    // G# A  A# B
    };

endpackage

/* note_if.sv */
`timescale 1ns/10ps

interface note_if;
    import synth_pkg::*;

    note_t      note;      // Raw key code, a valid name only while active
    logic [2:0] octave;
    logic       active;    // Key code below NOTE_COUNT
    logic       changed;   // One cycle on any new selection

    modport source (
        output note, octave, active, changed
    );

    modport sink (
        input note, octave, active, changed
    );

endinterface

/* key_note_decoder.sv */
`timescale 1ns/10ps
`include "synth_config.svh"

module key_note_decoder (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`SYNTH_KEY_W-1:0] key,
    input  logic [2:0]              octave_sel,
    note_if.source                  note_out
);
    import synth_pkg::*;

    localparam int SYNC_W = `SYNTH_KEY_W + 3;

    logic [SYNC_W-1:0]       sync_s1;
    logic [SYNC_W-1:0]       sync_s2;
    logic [1:0]              sync_fill;   // Stages holding real input
    logic [`SYNTH_KEY_W-1:0] key_s;
    logic [2:0]              octave_s;
    logic                    next_active;
    logic                    sel_diff;

    // Key and octave share one two-flop synchronizer
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync_s1   <= '0;
            sync_s2   <= '0;
            sync_fill <= '0;
        end else begin
            sync_s1   <= {key, octave_sel};
            sync_s2   <= sync_s1;
            sync_fill <= {sync_fill[0], 1'b1};
        end
    end

    assign {key_s, octave_s} = sync_s2;
    assign next_active = (key_s < NOTE_COUNT);

    assign sel_diff = (key_s != note_out.note) || (octave_s != note_out.octave)
                   || (next_active != note_out.active);

    // --------------------------------------------------
    // Published selection
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            note_out.note    <= NOTE_C;
            note_out.octave  <= 3'd0;
            note_out.active  <= 1'b0;
            note_out.changed <= 1'b0;
        end else if (sync_fill[1]) begin
            // Reset contents of the synchronizer never reach the bus
            note_out.note    <= note_t'(key_s);
            note_out.octave  <= octave_s;
            note_out.active  <= next_active;
            note_out.changed <= sel_diff;   // Same cycle as the new value
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        note_out.active |-> (note_out.note < NOTE_COUNT));

endmodule

/* square_osc.sv */
`timescale 1ns/10ps
`include "synth_config.svh"

module square_osc (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [31:0]                      half_period,
    input  logic                             enable,
    input  logic                             load,
    output logic signed [`SYNTH_SAMPLE_W-1:0] sample,
    output logic                             sample_valid,
    input  logic                             sample_ready
);

    localparam int PACE_W = $clog2(`SYNTH_SAMPLE_DIV);
    localparam logic signed [`SYNTH_SAMPLE_W-1:0] AMP = `SYNTH_SAMPLE_W'(`SYNTH_AMPLITUDE);

    logic [31:0]       phase;
    logic              level;
    logic [PACE_W-1:0] pace_cnt;
    logic              pace_tick;
    logic              take;

    // --------------------------------------------------
    // Phase counter, free of any sink influence
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
            level <= 1'b1;
        end else if (load) begin
            phase <= '0;
            level <= 1'b1;               // Restart high
        end else if (!enable) begin
            phase <= '0;
        end else if (phase == half_period - 32'd1) begin
            phase <= '0;
            level <= ~level;
        end else begin
            phase <= phase + 32'd1;
        end
    end

    // Sample opportunity pacing
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pace_cnt <= '0;
        else if (pace_tick)
            pace_cnt <= '0;
        else
            pace_cnt <= pace_cnt + 1'b1;
    end

    assign pace_tick = (pace_cnt == PACE_W'(`SYNTH_SAMPLE_DIV - 1));
    assign take      = sample_valid && sample_ready;

    // Opportunity under back-pressure is dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sample_valid <= 1'b0;
        else if (pace_tick && (!sample_valid || take))
            sample_valid <= 1'b1;
        else if (take)
            sample_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (pace_tick && (!sample_valid || take))
            sample <= !enable ? '0 : (level ? AMP : -AMP);
    end

    assert property (@(posedge clk) disable iff (rst)
        (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample)));

endmodule

/* tone_sel.sv */
`timescale 1ns/10ps
`include "synth_config.svh"

module tone_sel (
    input  logic                             clk,
    input  logic                             rst,
    note_if.sink                             note_in,
    output logic signed [`SYNTH_SAMPLE_W-1:0] sample,
    output logic                             sample_valid,
    input  logic                             sample_ready
);
    import synth_pkg::*;

    // Half period at octave zero, clk_hz * 500 / f_mhz
    function automatic logic [31:0] half_of(int idx);
        return 32'((64'(`SYNTH_CLK_HZ) * 64'd500) / 64'(note_freq_mhz[idx]));
    endfunction

    localparam logic [31:0] HALF_TAB [NOTE_COUNT] = '{
        half_of(0), half_of(1), half_of(2),  half_of(3),
        half_of(4), half_of(5), half_of(6),  half_of(7),
        half_of(8), half_of(9), half_of(10), half_of(11)
    };

    logic [31:0] half_period;
    logic        enable;
    logic        load;

    // --------------------------------------------------
    // Half-period register, one cycle after changed
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            half_period <= '0;
            enable      <= 1'b0;
            load        <= 1'b0;
        end else begin
            load <= note_in.changed;
            if (note_in.changed) begin
                enable <= note_in.active;
                if (note_in.active)
                    half_period <= HALF_TAB[note_in.note] >> note_in.octave;
                else
                    half_period <= '0;   // Silent, no period
            end
        end
    end

    square_osc u_square_osc (
        .clk          (clk),
        .rst          (rst),
        .half_period  (half_period),
        .enable       (enable),
        .load         (load),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    assert property (@(posedge clk) disable iff (rst)
        enable |-> (half_period != '0));

endmodule

/* seg_note_display.sv */
`timescale 1ns/10ps
`include "synth_config.svh"

module seg_note_display (
    input  logic                    clk,
    input  logic                    rst,
    note_if.sink                    note_in,
    output logic [7:0]              abcdefgh,
    output logic [7:0]              digit,
    output logic [`SYNTH_KEY_W-1:0] led
);
    import synth_pkg::*;

    // Letter on segments a..g, sharp on the point h
    function automatic logic [7:0] glyph_of(note_t n);
        logic [6:0] letter;
        logic       sharp;
        case (n)
            NOTE_C, NOTE_CS: letter = 7'b1001110;
            NOTE_D, NOTE_DS: letter = 7'b0111101;   // Lower case d
            NOTE_E:          letter = 7'b1001111;
            NOTE_F, NOTE_FS: letter = 7'b1000111;
            NOTE_G, NOTE_GS: letter = 7'b1011110;
            NOTE_A, NOTE_AS: letter = 7'b1110111;
            NOTE_B:          letter = 7'b0011111;   // Lower case b
            default:         letter = 7'b0000000;
        endcase
        sharp = (n inside {NOTE_CS, NOTE_DS, NOTE_FS, NOTE_GS, NOTE_AS});
        return {letter, sharp};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            abcdefgh <= 8'b0;
            digit    <= 8'b0;
            led      <= '0;
        end else begin
            led <= note_in.note;
            if (note_in.active) begin
                abcdefgh <= glyph_of(note_in.note);
                digit    <= 8'b0000_0001;   // Lowest digit only
            end else begin
                abcdefgh <= 8'b0;
                digit    <= 8'b0;
            end
        end
    end

endmodule

/* note_synth_top.sv */
`timescale 1ns/10ps
`include "synth_config.svh"

module note_synth_top (
    input  logic                             clk,
    input  logic                             rst,

    // Keys and LEDs
    input  logic [`SYNTH_KEY_W-1:0]          key,
    input  logic [2:0]                       octave_sel,
    output logic [`SYNTH_KEY_W-1:0]          led,

    // Seven-segment display
    output logic [7:0]                       abcdefgh,
    output logic [7:0]                       digit,

    // Audio sample stream
    output logic signed [`SYNTH_SAMPLE_W-1:0] sample,
    output logic                             sample_valid,
    input  logic                             sample_ready
);

    note_if note_bus ();

    // --------------------------------------------------
    // Key to note selection
    // --------------------------------------------------
    key_note_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .octave_sel (octave_sel),
        .note_out   (note_bus.source)
    );

    // Tone generation and sample stream
    tone_sel wave_gen (
        .clk          (clk),
        .rst          (rst),
        .note_in      (note_bus.sink),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    // --------------------------------------------------
    // Note name display
    // --------------------------------------------------
    seg_note_display u_display (
        .clk      (clk),
        .rst      (rst),
        .note_in  (note_bus.sink),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .led      (led)
    );

endmodule

/* tb_note_synth.sv */
`timescale 1ns/10ps
`include "synth_config.svh"

module tb_note_synth;
    import synth_pkg::*;

    localparam int DIV         = `SYNTH_SAMPLE_DIV;
    localparam int AMP         = `SYNTH_AMPLITUDE;
    localparam int BP_MAX_LOW  = 40;                       // Longest ready-low stretch
    localparam int SETTLE      = 4 * DIV + BP_MAX_LOW + 8; // Key path plus drain of old samples
    localparam int BP_TOL      = 2 * BP_MAX_LOW + 2 * DIV + 4;
    localparam int SIL_SAMPLES = 40;

    // C has the lowest table frequency, so the longest half period
    localparam longint HALF_MAX0 = (longint'(`SYNTH_CLK_HZ) * 500) / longint'(note_freq_mhz[0]);
    localparam longint MEAS_O5   = SETTLE + 2 * (HALF_MAX0 >> 5) + 2 * BP_TOL;
    localparam longint MEAS_O6   = SETTLE + 2 * (HALF_MAX0 >> 6) + 2 * BP_TOL;
    localparam longint MEAS_O7   = SETTLE + 2 * (HALF_MAX0 >> 7) + 2 * BP_TOL;
    localparam longint TEST_CYCLES = 20 + 16 * 7 + NOTE_COUNT * MEAS_O7
        + MEAS_O5 + MEAS_O6 + MEAS_O7 + 3 * (SETTLE + SIL_SAMPLES * DIV * 2) + 3 * MEAS_O7;
    localparam longint TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic                              clk;
    logic                              rst;
    logic [`SYNTH_KEY_W-1:0]           key;
    logic [2:0]                        octave_sel;
    logic [`SYNTH_KEY_W-1:0]           led;
    logic [7:0]                        abcdefgh;
    logic [7:0]                        digit;
    logic signed [`SYNTH_SAMPLE_W-1:0] sample;
    logic                              sample_valid;
    logic                              sample_ready;

    logic                              bp_mode;     // Random ready when set
    int                                low_run;
    longint                            cycle_cnt;
    logic                              was_held;
    logic signed [`SYNTH_SAMPLE_W-1:0] held_sample;
    int                                held_cycles;

    note_synth_top u_note_synth_top (
        .clk          (clk),
        .rst          (rst),
        .key          (key),
        .octave_sel   (octave_sel),
        .led          (led),
        .abcdefgh     (abcdefgh),
        .digit        (digit),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // Reporting and reference rules
    // --------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input longint got, input longint exp,
                             input longint tol);
        longint diff;
        diff = (got > exp) ? got - exp : exp - got;
        if (diff > tol)
            fail_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h (tolerance 0x%0h)",
                               name, got, exp, tol));
    endtask

    function automatic longint half_rule(int n, int oct);
        return ((longint'(`SYNTH_CLK_HZ) * 500) / longint'(note_freq_mhz[n])) >> oct;
    endfunction

    // Letter on a..g, sharp lights the point
    function automatic logic [7:0] glyph_rule(int k);
        string      names;
        byte        letter;
        logic [6:0] seg;
        names = "CCDDEFFGGAAB";
        if (k >= NOTE_COUNT)
            return 8'h00;
        letter = names[k];
        case (letter)
            "C":     seg = 7'b1001110;   // a d e f
            "D":     seg = 7'b0111101;   // Lower case d
            "E":     seg = 7'b1001111;
            "F":     seg = 7'b1000111;
            "G":     seg = 7'b1011110;
            "A":     seg = 7'b1110111;
            "B":     seg = 7'b0011111;   // Lower case b
            default: seg = 7'b0000000;
        endcase
        return {seg, (k inside {1, 3, 6, 8, 10})};
    endfunction

    // --------------------------------------------------
    // Background processes
    // --------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > TIMEOUT_CYCLES)
            fail_run("Timeout: the tests did not finish within the cycle limit");
    end

    always @(posedge clk) begin
        if (!bp_mode || low_run >= BP_MAX_LOW - 1 || ($urandom % 3) == 0) begin
            sample_ready <= 1'b1;
            low_run = 0;
        end else begin
            sample_ready <= 1'b0;
            low_run = low_run + 1;
        end
    end

    // Held sample must not move until accepted
    always @(posedge clk) begin
        if (rst) begin
            was_held = 1'b0;
        end else begin
            if (was_held) begin
                check_val("sample_valid while held", sample_valid, 1, 0);
                check_val("sample while held", sample, held_sample, 0);
            end
            was_held    = sample_valid && !sample_ready;
            held_sample = sample;
            if (was_held)
                held_cycles = held_cycles + 1;
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    task automatic set_key(input logic [3:0] k, input logic [2:0] oct);
        @(posedge clk);
        key        <= k;
        octave_sel <= oct;
    endtask

    // Cycles between the first two sign changes of accepted samples
    task automatic measure_half(output longint run);
        logic   prev_pos;
        logic   got_first;
        int     changes;
        longint t;
        longint t_first;
        run = 0;
        repeat (SETTLE) @(posedge clk);
        t         = 0;
        t_first   = 0;
        changes   = 0;
        got_first = 1'b0;
        prev_pos  = 1'b0;
        while (changes < 2) begin
            @(posedge clk);
            t = t + 1;
            if (sample_valid && sample_ready) begin
                if (!got_first) begin
                    got_first = 1'b1;
                    prev_pos  = (sample > 0);
                end else if ((sample > 0) != prev_pos) begin
                    prev_pos = (sample > 0);
                    changes  = changes + 1;
                    if (changes == 1)
                        t_first = t;
                    else
                        run = t - t_first;
                end
            end
        end
    endtask

    task automatic check_samples(input logic active, input int count);
        int     seen;
        longint mag;
        repeat (SETTLE) @(posedge clk);
        seen = 0;
        while (seen < count) begin
            @(posedge clk);
            if (sample_valid && sample_ready) begin
                seen = seen + 1;
                mag  = (sample < 0) ? -longint'(sample) : longint'(sample);
                if (active)
                    check_val("sample magnitude", mag, AMP, 0);
                else
                    check_val("silent sample", sample, 0, 0);
            end
        end
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic check_idle_outputs();
        check_val("sample_valid", sample_valid, 0, 0);
        check_val("abcdefgh", abcdefgh, 0, 0);
        check_val("digit", digit, 0, 0);
        check_val("led", led, 0, 0);
    endtask

    task automatic test_reset();
        repeat (10) begin
            @(posedge clk);
            check_idle_outputs();
        end
        rst <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            check_idle_outputs();
        end
    endtask

    task automatic test_display();
        for (int k = 0; k < 16; k++) begin
            set_key(4'(k), 3'd0);
            repeat (5) @(posedge clk);   // Four cycles of latency, seen at the next edge
            check_val($sformatf("led for key %0d", k), led, k, 0);
            check_val($sformatf("digit for key %0d", k), digit, (k < NOTE_COUNT) ? 1 : 0, 0);
            check_val($sformatf("abcdefgh for key %0d", k), abcdefgh, glyph_rule(k), 0);
        end
    endtask

    task automatic test_pitch();
        longint run;
        for (int n = 0; n < NOTE_COUNT; n++) begin
            set_key(4'(n), 3'd7);
            measure_half(run);
            check_val($sformatf("half period of note %0d", n), run, half_rule(n, 7), DIV);
        end
    endtask

    task automatic test_octave();
        longint h5;
        longint h6;
        longint h7;
        set_key(NOTE_A, 3'd5);
        measure_half(h5);
        check_val("half period at octave 5", h5, half_rule(NOTE_A, 5), DIV);
        set_key(NOTE_A, 3'd6);
        measure_half(h6);
        set_key(NOTE_A, 3'd7);
        measure_half(h7);
        // Both runs quantized to the sample grid
        check_val("octave 6 against half of octave 5", h6, h5 / 2, DIV + DIV / 2);
        check_val("octave 7 against half of octave 6", h7, h6 / 2, DIV + DIV / 2);
    endtask

    task automatic test_silence();
        set_key(4'd12, 3'd3);
        check_samples(1'b0, SIL_SAMPLES);
        set_key(4'd15, 3'd0);
        check_samples(1'b0, SIL_SAMPLES);
        set_key(NOTE_E, 3'd3);
        check_samples(1'b1, SIL_SAMPLES);
    endtask

    task automatic test_backpressure();
        longint run;
        int     notes [3];
        notes   = '{0, 6, 11};
        bp_mode = 1'b1;
        foreach (notes[i]) begin
            set_key(4'(notes[i]), 3'd7);
            measure_half(run);
            check_val($sformatf("half period of note %0d under back-pressure", notes[i]),
                      run, half_rule(notes[i], 7), BP_TOL);
        end
        bp_mode = 1'b0;
        check_val("back-pressure cycles seen", (held_cycles > 0) ? 1 : 0, 1, 0);
    endtask

    initial begin
        void'($urandom(32'h1e26_da89));
        clk          = 1'b0;
        rst          = 1'b1;
        key          = 4'd12;   // Start silent
        octave_sel   = 3'd0;
        sample_ready = 1'b0;
        bp_mode      = 1'b0;
        low_run      = 0;
        cycle_cnt    = 0;
        was_held     = 1'b0;
        held_sample  = '0;
        held_cycles  = 0;
        test_reset();
        test_display();
        test_pitch();
        test_octave();
        test_silence();
        test_backpressure();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* compile.f */
+incdir+.
synth_pkg.sv
note_if.sv
key_note_decoder.sv
square_osc.sv
tone_sel.sv
seg_note_display.sv
note_synth_top.sv
tb_note_synth.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the tone synthesizer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_note_synth \
    -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Vtb_note_synth
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished without errors"
exit 0
